// File: run.sh
#!/bin/sh
# build and run the lut_engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module lut_engine_tb -o lut_engine_sim \
    && ./obj_dir/lut_engine_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/line_fifo.sv
`default_nettype none
`include "lut_cfg.svh"

module line_fifo import lut_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,

    input  lut_line_t i_data,
    input  wire       i_wrreq,
    input  wire       i_rdreq,

    output lut_line_t o_q,
    output logic      o_empty,
    output logic      o_full
);

    localparam int PTR_W = $clog2(`LUT_FIFO_DEPTH);

    lut_line_t        mem [`LUT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = i_wrreq && !o_full;    // drop when full.
    assign do_rd = i_rdreq && !o_empty;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge clk) begin
        if (do_rd)
            o_q <= mem[rd_ptr];    // valid the cycle after rdreq.
    end

    ////////////////////////////////////////
    // pointers and level
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth.
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (do_wr && !do_rd)
            count <= count + 1'b1;
        else if (do_rd && !do_wr)
            count <= count - 1'b1;
    end

    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W + 1)'(`LUT_FIFO_DEPTH));

endmodule

`default_nettype wire

// File: source/lut_apply.sv
`default_nettype none

module lut_apply import lut_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,

    input  lut_byte_t i_pix,
    input  wire       i_pix_valid,
    input  wire       i_bypass,

    // table read port
    input  lut_byte_t i_rdata,
    output lut_addr_t o_raddr,

    output lut_byte_t o_pix,
    output logic      o_pix_valid
);

    logic      s1_valid;
    logic      s1_bypass;
    lut_byte_t s1_pix;

    assign o_raddr = i_pix;    // pixel value is the index.

    ////////////////////////////////////////
    // stage 1, aligned with ram read
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= i_pix_valid;
    end

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            s1_bypass <= i_bypass;    // sampled with the pixel.
            s1_pix    <= i_pix;
        end
    end

    ////////////////////////////////////////
    // stage 2, select and register
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            o_pix_valid <= 1'b0;
        else
            o_pix_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        if (s1_valid)
            o_pix <= s1_bypass ? s1_pix : i_rdata;
    end

endmodule

`default_nettype wire

// File: source/lut_cfg.svh
`ifndef LUT_CFG_SVH
`define LUT_CFG_SVH

////////////////////////////////////////
// table line geometry
////////////////////////////////////////

`define LUT_LINE_W      128                        // bits per host line.
`define LUT_PIX_W       8                          // pixel and entry width.
`define LUT_LINE_BYTES  (`LUT_LINE_W / `LUT_PIX_W) // entries per line.

////////////////////////////////////////
// storage sizes
////////////////////////////////////////

// lines buffered ahead of the fetch machine
`define LUT_FIFO_DEPTH  16

`define LUT_DEPTH       256                  // table entries.
`define LUT_ADDR_W      $clog2(`LUT_DEPTH)   // table address bits.

`endif

// File: source/lut_engine.sv
`default_nettype none

module lut_engine import lut_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,

    // table load
    input  lut_line_t i_line,
    input  wire       i_line_we,
    output logic      o_full,
    output logic      o_done,

    // pixel stream
    input  lut_byte_t i_pix,
    input  wire       i_pix_valid,
    input  wire       i_bypass,
    output lut_byte_t o_pix,
    output logic      o_pix_valid
);

    logic      ram_we;
    lut_addr_t ram_waddr;
    lut_byte_t ram_wdata;
    lut_addr_t ram_raddr;
    lut_byte_t ram_rdata;

    ////////////////////////////////////////
    // table loading
    ////////////////////////////////////////

    lut_fetch_fifo u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_line     (i_line),
        .i_line_we  (i_line_we),
        .o_ram_we   (ram_we),
        .o_ram_addr (ram_waddr),
        .o_ram_data (ram_wdata),
        .o_done     (o_done),
        .o_full     (o_full)
    );

    lut_ram u_ram (
        .clk     (clk),
        .i_we    (ram_we),
        .i_waddr (ram_waddr),
        .i_wdata (ram_wdata),
        .i_raddr (ram_raddr),
        .o_rdata (ram_rdata)
    );

    ////////////////////////////////////////
    // pixel lookup
    ////////////////////////////////////////

    // two cycles from i_pix_valid to o_pix_valid.
    lut_apply u_apply (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_pix       (i_pix),
        .i_pix_valid (i_pix_valid),
        .i_bypass    (i_bypass),
        .i_rdata     (ram_rdata),
        .o_raddr     (ram_raddr),
        .o_pix       (o_pix),
        .o_pix_valid (o_pix_valid)
    );

endmodule

`default_nettype wire

// File: source/lut_fetch_fifo.sv
`default_nettype none
`include "lut_cfg.svh"

module lut_fetch_fifo import lut_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,

    // host line input
    input  lut_line_t i_line,
    input  wire       i_line_we,

    // table memory write port
    output logic      o_ram_we,
    output lut_addr_t o_ram_addr,
    output lut_byte_t o_ram_data,

    output logic      o_done,
    output logic      o_full
);

    localparam int IDX_W = $clog2(`LUT_LINE_BYTES);

    lut_line_t        fifo_q;
    logic             fifo_empty;
    logic             fifo_rdreq;
    lut_line_t        line_buf;
    logic             line_buf_ld;
    logic [IDX_W-1:0] byte_idx;
    fetch_state_t     state;
    fetch_state_t     nxt_state;

    line_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_data  (i_line),
        .i_wrreq (i_line_we),
        .i_rdreq (fifo_rdreq),
        .o_q     (fifo_q),
        .o_empty (fifo_empty),
        .o_full  (o_full)
    );

    ////////////////////////////////////////
    // line buffer and byte select
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_buf_ld)
            line_buf <= fifo_q;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            byte_idx <= '0;
        else if (o_ram_we)
            byte_idx <= byte_idx + 1'b1;    // back to 0 after last byte.
    end

    assign o_ram_data = line_buf[byte_idx];

    // free running, so line 17 lands on entry 0 again
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            o_ram_addr <= '0;
        else if (o_ram_we)
            o_ram_addr <= o_ram_addr + 1'b1;
    end

    ////////////////////////////////////////
    // fetch state machine
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        fifo_rdreq  = 1'b0;
        line_buf_ld = 1'b0;
        o_ram_we    = 1'b0;
        nxt_state   = state;

        case (state)
            ST_IDLE: begin
                if (!fifo_empty) begin
                    fifo_rdreq = 1'b1;
                    nxt_state  = ST_READ_FIFO;
                end
            end
            ST_READ_FIFO: begin
                line_buf_ld = 1'b1;    // q is valid now.
                nxt_state   = ST_WRITE_RAM;
            end
            ST_WRITE_RAM: begin
                o_ram_we = 1'b1;
                if (byte_idx == IDX_W'(`LUT_LINE_BYTES - 1))
                    nxt_state = ST_IDLE;
            end
            default: nxt_state = ST_IDLE;
        endcase
    end

    assign o_done = (state == ST_IDLE) && fifo_empty;

endmodule

`default_nettype wire

// File: source/lut_pkg.sv
`include "lut_cfg.svh"

package lut_pkg;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////

    // one table entry, also one pixel
    typedef logic [`LUT_PIX_W-1:0] lut_byte_t;

    // byte 0 sits in bits 7..0 and goes to the lowest address.
    typedef lut_byte_t [`LUT_LINE_BYTES-1:0] lut_line_t;

    typedef logic [`LUT_ADDR_W-1:0] lut_addr_t;    // table address.

    ////////////////////////////////////////
    // fetch machine
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for a line.
        ST_READ_FIFO,   // fifo q valid, load buffer.
        ST_WRITE_RAM    // sixteen byte writes.
    } fetch_state_t;

endpackage

// File: source/lut_ram.sv
`default_nettype none
`include "lut_cfg.svh"

module lut_ram import lut_pkg::*; (
    input  wire       clk,

    // write side, from fetch
    input  wire       i_we,
    input  lut_addr_t i_waddr,
    input  lut_byte_t i_wdata,

    // read side, from pixel path
    input  lut_addr_t i_raddr,
    output lut_byte_t o_rdata
);

    lut_byte_t mem [`LUT_DEPTH];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // one cycle read latency, every cycle.
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/lut_pkg.sv
source/line_fifo.sv
source/lut_fetch_fifo.sv
source/lut_ram.sv
source/lut_apply.sv
source/lut_engine.sv
tests/lut_engine_props.sv
tests/lut_engine_tb.sv

// File: tests/lut_engine_props.sv
module lut_engine_props import lut_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      i_ram_we,
    input lut_addr_t i_ram_addr,
    input logic      i_done,
    input logic      i_pix_valid,
    input logic      i_out_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [4:0] we_run;    // consecutive write cycles.

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            we_run <= '0;
        else if (i_ram_we)
            we_run <= we_run + 1'b1;
        else
            we_run <= '0;
    end

    ////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////

    a_we_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(i_ram_we) |-> we_run == 5'd16) else $error("ram write burst of %0d cycles", we_run);

    a_we_max: assert property (@(posedge clk) disable iff (!rst_n)
        i_ram_we |-> we_run < 5'd16) else $error("ram write burst longer than a line");

    a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(i_ram_we) |-> i_ram_addr == lut_addr_t'($past(i_ram_addr) + 1'b1))
        else $error("ram write address did not advance by one");

    // a new line needs a read cycle and a load cycle before its first write
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |-> !i_ram_we ##1 !i_ram_we ##1 !i_ram_we)
        else $error("ram write within two cycles of done");

    ////////////////////////////////////////
    // pixel side
    ////////////////////////////////////////

    a_pix_lat: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid == $past(i_pix_valid, 2)) else $error("pixel valid latency is not 2");

endmodule

bind lut_fetch_fifo lut_engine_props u_fetch_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ram_we    (o_ram_we),
    .i_ram_addr  (o_ram_addr),
    .i_done      (o_done),
    .i_pix_valid (1'b0),
    .i_out_valid (1'b0)
);

bind lut_apply lut_engine_props u_apply_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_ram_we    (1'b0),
    .i_ram_addr  (8'd0),
    .i_done      (1'b0),
    .i_pix_valid (i_pix_valid),
    .i_out_valid (o_pix_valid)
);

// File: tests/lut_engine_tb.sv
`include "lut_cfg.svh"

module lut_engine_tb import lut_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string name;
        int    lines;     // lines loaded before lookups.
        int    gap;       // idle cycles after each line.
        bit    exp_full;  // o_full once loading stops.
        bit    sweep;     // look up every entry in order.
        int    pixels;    // random pixels when not sweeping.
        int    bypass;    // 0 off, 1 on, 2 alternating.
    } test_t;

    localparam int NUM_TESTS = 6;
    localparam int WAIT_LIMIT = 2000;

    logic      clk = 1'b0;
    logic      rst_n;
    lut_line_t i_line;
    logic      i_line_we;
    lut_byte_t i_pix;
    logic      i_pix_valid;
    logic      i_bypass;
    logic      o_full;
    logic      o_done;
    lut_byte_t o_pix;
    logic      o_pix_valid;

    test_t       tests [NUM_TESTS];
    lut_byte_t   model [`LUT_DEPTH];
    lut_addr_t   model_ptr;
    logic [31:0] rng;
    int          checks;
    int          errors;
    int          timeouts;

    lut_engine uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_line      (i_line),
        .i_line_we   (i_line_we),
        .o_full      (o_full),
        .o_done      (o_done),
        .i_pix       (i_pix),
        .i_pix_valid (i_pix_valid),
        .i_bypass    (i_bypass),
        .o_pix       (o_pix),
        .o_pix_valid (o_pix_valid)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic lut_byte_t rand_byte();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[23:16];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_level(input string what, input bit want_done);
        int waited;
        waited = 0;
        while ((want_done ? !o_done : o_full) && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (want_done ? !o_done : o_full) begin
            timeouts++;
            $display("timed out waiting for %s", what);
        end
    endtask

    task automatic write_line();
        lut_line_t line;
        for (int b = 0; b < `LUT_LINE_BYTES; b++)
            line[b] = rand_byte();
        wait_level("the line FIFO to leave full", 1'b0);
        i_line    = line;
        i_line_we = 1'b1;
        next_cycle();
        i_line_we = 1'b0;
        for (int b = 0; b < `LUT_LINE_BYTES; b++) begin
            model[model_ptr] = line[b];    // entry k is byte k mod 16.
            model_ptr        = model_ptr + 8'd1;
        end
    endtask

    task automatic run_pixels(input int t);
        lut_byte_t pix;
        lut_byte_t expect_q [$];
        logic      byp;
        int        total;
        total = tests[t].sweep ? `LUT_DEPTH : tests[t].pixels;
        for (int c = 0; c < total + 2; c++) begin
            if (c >= 2) begin    // pixel c-2 is due now.
                check_value({tests[t].name, " valid"}, 32'd1, 32'(o_pix_valid));
                check_value({tests[t].name, " pixel"}, 32'(expect_q.pop_front()), 32'(o_pix));
            end else begin
                check_value({tests[t].name, " lead"}, 32'd0, 32'(o_pix_valid));
            end
            if (c < total) begin
                pix = tests[t].sweep ? lut_byte_t'(c) : rand_byte();
                byp = (tests[t].bypass == 2) ? c[0] : (tests[t].bypass == 1);
                i_pix       = pix;
                i_pix_valid = 1'b1;
                i_bypass    = byp;
                expect_q.push_back(byp ? pix : model[pix]);
            end else begin
                i_pix_valid = 1'b0;
                i_bypass    = 1'b0;
            end
            next_cycle();
        end
        check_value({tests[t].name, " drained"}, 32'd0, 32'(o_pix_valid));
    endtask

    ////////////////////////////////////////
    // test table and sequence
    ////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        i_line      = '0;
        i_line_we   = 1'b0;
        i_pix       = '0;
        i_pix_valid = 1'b0;
        i_bypass    = 1'b0;
        rng         = 32'd18809;
        model_ptr   = '0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        tests[0] = '{"full_load", 16, 19, 1'b0, 1'b1, 0, 0};
        tests[1] = '{"burst_load", 17, 0, 1'b1, 1'b1, 0, 0};    // 17th line fills it.
        tests[2] = '{"pixel_stream", 0, 0, 1'b0, 1'b0, 200, 0};
        tests[3] = '{"bypass", 0, 0, 1'b0, 1'b0, 100, 1};
        tests[4] = '{"bypass_toggle", 0, 0, 1'b0, 1'b0, 100, 2};
        tests[5] = '{"wrap_around", 4, 20, 1'b0, 1'b1, 0, 0};    // rest keeps old lines.

        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_value("reset done", 32'd1, 32'(o_done));
        check_value("reset valid", 32'd0, 32'(o_pix_valid));
        check_value("reset full", 32'd0, 32'(o_full));

        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int n = 0; n < tests[t].lines; n++) begin
                write_line();
                repeat (tests[t].gap) next_cycle();
            end
            if (tests[t].lines > 0)
                check_value({tests[t].name, " full"}, 32'(tests[t].exp_full), 32'(o_full));
            wait_level("done after loading lines", 1'b1);
            run_pixels(t);
        end

        $display("checks %0d  errors %0d  timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
